/* spi_cmd_bridge.f */
+incdir+verification
src/spi_frame_pkg.sv
src/reg_map_pkg.sv
src/frame_if.sv
src/reg_if.sv
src/spi_frame_port.sv
src/cmd_decoder.sv
src/reg_bank.sv
src/spi_cmd_bridge.sv
verification/spi_cmd_bridge_tb.sv

/* Makefile */
# Verilator build and run of the SPI register bridge testbench

SRCS := $(wildcard src/*.sv) $(wildcard verification/*.sv verification/*.svh)

.PHONY: run clean

run: obj_dir/Vspi_cmd_bridge_tb
	obj_dir/Vspi_cmd_bridge_tb | tee sim.log
	grep -q "All tests passed" sim.log

obj_dir/Vspi_cmd_bridge_tb: spi_cmd_bridge.f $(SRCS)
	verilator --binary --timing --assert --top-module spi_cmd_bridge_tb \
		-f spi_cmd_bridge.f -o Vspi_cmd_bridge_tb

clean:
	rm -rf obj_dir sim.log

/* verification/spi_host.svh */
// SPI master driver for the testbench
`ifndef SPI_HOST_SVH
`define SPI_HOST_SVH

localparam int SCK_HALF_CLKS = 4; // clk cycles per sck phase.
localparam int SS_GAP_CLKS   = 8; // deselect time between frames.

// mode 0, LSB first; miso is sampled as sck rises.
task automatic spi_transfer(input spi_frame_pkg::cmd_frame_s tx_word,
                            output spi_frame_pkg::rsp_frame_s rx_word);
   logic [spi_frame_pkg::FRAME_BITS-1:0] tx_bits;
   logic [spi_frame_pkg::FRAME_BITS-1:0] rx_bits;
   tx_bits = tx_word;
   rx_bits = '0;
   @(posedge clk);
   spi_ss   <= 1'b0;
   spi_mosi <= tx_bits[0];
   for (int b = 0; b < spi_frame_pkg::FRAME_BITS; b++) begin
      repeat (SCK_HALF_CLKS) @(posedge clk);
      rx_bits[b] = spi_miso;
      spi_sck <= 1'b1;
      repeat (SCK_HALF_CLKS) @(posedge clk);
      spi_sck <= 1'b0;
      if (b < spi_frame_pkg::FRAME_BITS - 1) begin
         spi_mosi <= tx_bits[b + 1]; // next bit set up while sck is low.
      end
   end
   repeat (SCK_HALF_CLKS) @(posedge clk);
   spi_ss <= 1'b1;
   repeat (SS_GAP_CLKS) @(posedge clk);
   rx_word = rx_bits;
endtask

`endif

/* verification/spi_cmd_bridge_tb.sv */
// SPI register bridge testbench
`timescale 1ns/1ps

module spi_cmd_bridge_tb;

   localparam int CLK_HALF_NS   = 50;
   localparam int REG_WAIT_CLKS = 16; // settle limit for reg_value.

   typedef struct {
      logic [3:0]             cmd;
      logic [3:0]             addr;
      logic [23:0]            data;
      logic [7:0]             hw;
      logic [7:0]             exp_status; // reply to the previous row.
      logic [23:0]            exp_data;
      logic [3:0]             sel;
      reg_map_pkg::reg_word_t exp_reg;
   } row_t;

   logic                   clk;
   logic                   reset;
   logic                   spi_sck;
   logic                   spi_ss;
   logic                   spi_mosi;
   logic                   spi_miso;
   logic [7:0]             hw_status;
   logic [3:0]             reg_sel;
   reg_map_pkg::reg_word_t reg_value;

   row_t rows [$];
   int   checks;
   int   errors;

   `include "spi_host.svh"

   spi_cmd_bridge u_dut (
      .clk       (clk),
      .reset     (reset),
      .spi_sck   (spi_sck),
      .spi_ss    (spi_ss),
      .spi_mosi  (spi_mosi),
      .spi_miso  (spi_miso),
      .hw_status (hw_status),
      .reg_sel   (reg_sel),
      .reg_value (reg_value)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_HALF_NS) clk = ~clk;
   end

   // status byte is the command echo over the OK or error flag.
   function automatic logic [7:0] ok_status(input logic [3:0] cmd);
      return {cmd, 4'b0001};
   endfunction

   function automatic logic [7:0] err_status(input logic [3:0] cmd);
      return {cmd, 4'b0010};
   endfunction

   task automatic add_row(input logic [3:0] cmd, input logic [3:0] addr,
                          input logic [23:0] data, input logic [7:0] hw,
                          input logic [7:0] exp_status, input logic [23:0] exp_data,
                          input logic [3:0] sel, input reg_map_pkg::reg_word_t exp_reg);
      rows.push_back('{cmd, addr, data, hw, exp_status, exp_data, sel, exp_reg});
   endtask

   task automatic build_table();
      add_row(reg_map_pkg::CMD_NOP, 4'd0, 24'h000000, 8'h00, 8'h00, 24'h000000, 4'd0, 16'h0000);
      add_row(reg_map_pkg::CMD_WRITE, 4'd3, 24'hAB1234, 8'h5A,
              ok_status(reg_map_pkg::CMD_NOP), 24'h000000, 4'd3, 16'h1234);
      add_row(reg_map_pkg::CMD_READ, 4'd3, 24'h000000, 8'hC3,
              ok_status(reg_map_pkg::CMD_WRITE), 24'h5A1234, 4'd3, 16'h1234);
      add_row(reg_map_pkg::CMD_WRITE, 4'd12, 24'h00BEEF, 8'h11,
              ok_status(reg_map_pkg::CMD_READ), 24'hC31234, 4'd3, 16'h1234);
      add_row(reg_map_pkg::CMD_READ, 4'd15, 24'h000000, 8'h22,
              err_status(reg_map_pkg::CMD_WRITE), 24'h000000, 4'd4, 16'h0000);
      add_row(4'h7, 4'd1, 24'h123456, 8'h33,
              err_status(reg_map_pkg::CMD_READ), 24'h000000, 4'd1, 16'h0000);
      add_row(reg_map_pkg::CMD_NOP, 4'd0, 24'h000000, 8'h44,
              err_status(4'h7), 24'h000000, 4'd1, 16'h0000);
      add_row(reg_map_pkg::CMD_WRITE, 4'd0, 24'h00CAFE, 8'h66,
              ok_status(reg_map_pkg::CMD_NOP), 24'h000000, 4'd0, 16'hCAFE);
      add_row(reg_map_pkg::CMD_WRITE, 4'd11, 24'hFF8001, 8'h77,
              ok_status(reg_map_pkg::CMD_WRITE), 24'h66CAFE, 4'd11, 16'h8001);
      add_row(reg_map_pkg::CMD_WRITE, 4'd5, 24'h000055, 8'h88,
              ok_status(reg_map_pkg::CMD_WRITE), 24'h778001, 4'd5, 16'h0055);
      add_row(reg_map_pkg::CMD_READ, 4'd0, 24'h000000, 8'h99,
              ok_status(reg_map_pkg::CMD_WRITE), 24'h880055, 4'd0, 16'hCAFE);
      add_row(reg_map_pkg::CMD_READ, 4'd11, 24'h000000, 8'hAA,
              ok_status(reg_map_pkg::CMD_READ), 24'h99CAFE, 4'd11, 16'h8001);
      add_row(reg_map_pkg::CMD_NOP, 4'd0, 24'h000000, 8'hBB,
              ok_status(reg_map_pkg::CMD_READ), 24'hAA8001, 4'd3, 16'h1234);
   endtask

   task automatic check_status(input string name, input logic [7:0] got,
                               input logic [7:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Error at %0t: %s expected %02h, got %02h", $time, name, exp, got);
      end
   endtask

   task automatic check_data(input string name, input logic [23:0] got,
                             input logic [23:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Error at %0t: %s expected %06h, got %06h", $time, name, exp, got);
      end
   endtask

   task automatic check_reg(input string name, input reg_map_pkg::reg_word_t got,
                            input reg_map_pkg::reg_word_t exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Error at %0t: %s expected %04h, got %04h", $time, name, exp, got);
      end
   endtask

   task automatic wait_reg(input reg_map_pkg::reg_word_t exp);
      bit settled;
      settled = 1'b0;
      for (int n = 0; n < REG_WAIT_CLKS && !settled; n++) begin
         @(posedge clk);
         settled = (reg_value === exp);
      end
      if (!settled) begin
         $display("reg_value for reg_sel %0d did not settle within %0d clock cycles.",
                  reg_sel, REG_WAIT_CLKS);
      end
      check_reg("reg_value", reg_value, exp);
   endtask

   initial begin
      spi_frame_pkg::cmd_frame_s cmd_word;
      spi_frame_pkg::rsp_frame_s rsp_word;
      int                        errors_before;

      reset     = 1'b1;
      spi_sck   = 1'b0;
      spi_ss    = 1'b1;
      spi_mosi  = 1'b0;
      hw_status = '0;
      reg_sel   = '0;
      checks    = 0;
      errors    = 0;
      build_table();

      repeat (2) @(posedge clk);
      reset <= 1'b0;

      // unimplemented addresses read zero as well.
      errors_before = errors;
      for (int s = 0; s < 16; s++) begin
         @(posedge clk);
         reg_sel <= 4'(s);
         wait_reg('0);
      end
      $display("reset sweep: %0s", (errors == errors_before) ? "ok" : "mismatch");

      foreach (rows[i]) begin
         errors_before = errors;
         @(posedge clk);
         hw_status <= rows[i].hw;
         cmd_word.opcode.cmd  = rows[i].cmd;
         cmd_word.opcode.addr = rows[i].addr;
         {cmd_word.byte2, cmd_word.byte1, cmd_word.byte0} = rows[i].data;
         spi_transfer(cmd_word, rsp_word);
         check_status("reply status", rsp_word.status, rows[i].exp_status);
         check_data("reply data", rsp_word.data, rows[i].exp_data);
         @(posedge clk);
         reg_sel <= rows[i].sel;
         wait_reg(rows[i].exp_reg);
         $display("row %0d cmd %h addr %0d: %0s", i, rows[i].cmd, rows[i].addr,
                  (errors == errors_before) ? "ok" : "mismatch");
      end

      $display("%0d rows, %0d checks, %0d errors", rows.size(), checks, errors);
      if (errors == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

endmodule

/* src/spi_cmd_bridge.sv */
// SPI register bridge top level
`timescale 1ns/1ps

module spi_cmd_bridge #(
   parameter int NUM_REGS = 12
) (
   input  logic        clk,
   input  logic        reset,
   input  logic        spi_sck,
   input  logic        spi_ss,
   input  logic        spi_mosi,
   output logic        spi_miso,
   input  logic [7:0]  hw_status,
   input  logic [3:0]  reg_sel,
   output logic [15:0] reg_value
);

   frame_if frame_bus ();
   reg_if   reg_bus ();

   spi_frame_port u_port (
      .clk      (clk),
      .reset    (reset),
      .spi_sck  (spi_sck),
      .spi_ss   (spi_ss),
      .spi_mosi (spi_mosi),
      .spi_miso (spi_miso),
      .frame    (frame_bus.port)
   );

   cmd_decoder #(.NUM_REGS(NUM_REGS)) u_decoder (
      .clk       (clk),
      .reset     (reset),
      .hw_status (hw_status),
      .frame     (frame_bus.decoder),
      .regs      (reg_bus.master)
   );

   reg_bank #(.NUM_REGS(NUM_REGS)) u_bank (
      .clk       (clk),
      .reset     (reset),
      .reg_sel   (reg_sel),
      .reg_value (reg_value),
      .regs      (reg_bus.bank)
   );

endmodule

/* src/reg_bank.sv */
// Register bank
`timescale 1ns/1ps

module reg_bank #(
   parameter int NUM_REGS = 12
) (
   input  logic                   clk,
   input  logic                   reset,
   input  logic [3:0]             reg_sel,
   output reg_map_pkg::reg_word_t reg_value,
   reg_if.bank                    regs
);

   reg_map_pkg::reg_word_t bank_q [NUM_REGS];

   function automatic reg_map_pkg::reg_word_t read_word(input logic [3:0] a);
      read_word = '0; // unimplemented addresses read zero.
      if (int'(a) < NUM_REGS) begin
         read_word = bank_q[a];
      end
   endfunction

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < NUM_REGS; i++) begin
            bank_q[i] <= '0;
         end
      end else if (regs.wr_en) begin
         bank_q[regs.addr] <= regs.wdata;
      end
   end

   assign regs.rdata = read_word(regs.addr);
   assign reg_value  = read_word(reg_sel);

   a_wr_in_range : assert property (@(posedge clk) disable iff (reset)
      regs.wr_en |-> int'(regs.addr) < NUM_REGS)
      else $error("write to unimplemented register.");

endmodule

/* src/cmd_decoder.sv */
// Command decoder and reply builder
`timescale 1ns/1ps

module cmd_decoder #(
   parameter int NUM_REGS = 12
) (
   input  logic        clk,
   input  logic        reset,
   input  logic [7:0]  hw_status,
   frame_if.decoder    frame,
   reg_if.master       regs
);

   spi_frame_pkg::cmd_frame_s  rx_cmd;
   spi_frame_pkg::frame_word_u reply;
   logic                       addr_ok;
   logic                       is_write;
   logic                       is_read;
   logic                       is_ok;
   logic                       load_pend;
   logic [3:0]                 cmd_q;
   logic [3:0]                 addr_q;
   logic                       ok_q;
   logic                       access_q;

   assign rx_cmd  = frame.rx_word.cmd;
   assign addr_ok = int'(rx_cmd.opcode.addr) < NUM_REGS;

   always_comb begin
      is_write = 1'b0;
      is_read  = 1'b0;
      is_ok    = 1'b0;
      case (rx_cmd.opcode.cmd)
         reg_map_pkg::CMD_NOP: begin
            is_ok = 1'b1;
         end
         reg_map_pkg::CMD_WRITE: begin
            is_write = addr_ok;
            is_ok    = addr_ok;
         end
         reg_map_pkg::CMD_READ: begin
            is_read = addr_ok;
            is_ok   = addr_ok;
         end
         default: is_ok = 1'b0; // unknown code.
      endcase
   end

   // every frame is taken as soon as it shows up.
   assign frame.rx_ack = frame.rx_valid;

   // write lands with the ack; readback uses the held address a cycle later.
   assign regs.wr_en = frame.rx_valid & is_write;
   assign regs.addr  = frame.rx_valid ? rx_cmd.opcode.addr : addr_q;
   assign regs.wdata = {rx_cmd.byte1, rx_cmd.byte0};

   always_ff @(posedge clk) begin
      if (reset) begin
         load_pend <= 1'b0;
      end else if (frame.rx_valid) begin
         load_pend <= 1'b1;
      end else if (frame.tx_load) begin
         load_pend <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (frame.rx_valid) begin
         cmd_q    <= rx_cmd.opcode.cmd;
         addr_q   <= rx_cmd.opcode.addr;
         ok_q     <= is_ok;
         access_q <= is_write | is_read;
      end
   end

   always_comb begin
      reply = '0;
      reply.rsp.status[reg_map_pkg::STAT_CMD_MSB:reg_map_pkg::STAT_CMD_LSB] = cmd_q;
      reply.rsp.status[reg_map_pkg::STAT_OK_BIT]  = ok_q;
      reply.rsp.status[reg_map_pkg::STAT_ERR_BIT] = ~ok_q;
      if (access_q) begin
         reply.rsp.data = {hw_status, regs.rdata}; // live status byte.
      end
   end

   assign frame.tx_load = load_pend & frame.tx_free;
   assign frame.tx_word = reply;

endmodule

/* src/spi_frame_port.sv */
// SPI mode 0 frame port, LSB first
`timescale 1ns/1ps

module spi_frame_port (
   input  logic    clk,
   input  logic    reset,
   input  logic    spi_sck,
   input  logic    spi_ss,
   input  logic    spi_mosi,
   output logic    spi_miso,
   frame_if.port   frame
);

   localparam int CNT_W = $clog2(spi_frame_pkg::FRAME_BITS);

   logic [2:0]                             sck_q; // two sync stages, then edge history.
   logic [2:0]                             ss_q;
   logic [1:0]                             mosi_q;
   logic                                   ss_active;
   logic                                   ss_fall;
   logic                                   sck_rise;
   logic                                   sck_fall;
   logic                                   frame_done;
   logic [CNT_W-1:0]                       bit_cnt;
   logic [spi_frame_pkg::FRAME_BITS-1:0]   rx_shift;
   logic [spi_frame_pkg::FRAME_BITS-1:0]   tx_shift;
   logic                                   rx_valid_q;

   assign ss_active  = ~ss_q[1];
   assign ss_fall    = ss_q[2] & ~ss_q[1];
   assign sck_rise   = ss_active & sck_q[1] & ~sck_q[2];
   assign sck_fall   = ss_active & ~sck_q[1] & sck_q[2];
   assign frame_done = sck_rise && (bit_cnt == CNT_W'(spi_frame_pkg::FRAME_BITS - 1));

   assign spi_miso       = tx_shift[0];
   assign frame.rx_valid = rx_valid_q;
   assign frame.tx_free  = (bit_cnt == '0); // nothing shifted yet in this frame.

   always_ff @(posedge clk) begin
      if (reset) begin
         sck_q      <= '0;
         ss_q       <= '1; // idle deselected.
         mosi_q     <= '0;
         bit_cnt    <= '0;
         rx_valid_q <= 1'b0;
         tx_shift   <= '0;
      end else begin
         sck_q  <= {sck_q[1:0], spi_sck};
         ss_q   <= {ss_q[1:0], spi_ss};
         mosi_q <= {mosi_q[0], spi_mosi};

         if (ss_fall) begin
            bit_cnt <= '0;
         end else if (sck_rise) begin
            bit_cnt <= frame_done ? '0 : bit_cnt + 1'b1;
         end

         // a new frame wins over an ack of the old one.
         if (frame_done) begin
            rx_valid_q <= 1'b1;
         end else if (frame.rx_ack) begin
            rx_valid_q <= 1'b0;
         end

         // trailing falling edge after the last bit does not shift.
         if (frame.tx_load) begin
            tx_shift <= frame.tx_word;
         end else if (sck_fall && bit_cnt != '0) begin
            tx_shift <= {1'b0, tx_shift[spi_frame_pkg::FRAME_BITS-1:1]};
         end
      end
   end

   always_ff @(posedge clk) begin
      if (sck_rise) begin
         rx_shift <= {mosi_q[1], rx_shift[spi_frame_pkg::FRAME_BITS-1:1]};
      end
      if (frame_done) begin
         frame.rx_word <= {mosi_q[1], rx_shift[spi_frame_pkg::FRAME_BITS-1:1]};
      end
   end

   a_valid_held : assert property (@(posedge clk) disable iff (reset)
      frame.rx_valid && !frame.rx_ack |=> frame.rx_valid)
      else $error("rx_valid dropped before ack.");

   a_load_free : assert property (@(posedge clk) disable iff (reset)
      frame.tx_load |-> frame.tx_free)
      else $error("reply loaded while a frame was shifting.");

endmodule

/* src/reg_if.sv */
// Register access bus
`timescale 1ns/1ps

interface reg_if;

   logic                  wr_en;
   logic [3:0]            addr;
   reg_map_pkg::reg_word_t wdata;
   reg_map_pkg::reg_word_t rdata; // combinational read of addr.

   modport master (
      output wr_en, addr, wdata,
      input  rdata
   );

   modport bank (
      input  wr_en, addr, wdata,
      output rdata
   );

endinterface

/* src/frame_if.sv */
// Frame handoff between SPI port and decoder
`timescale 1ns/1ps

interface frame_if;

   logic                      rx_valid; // a received frame waits.
   spi_frame_pkg::frame_word_u rx_word;
   logic                      rx_ack;
   logic                      tx_free;  // shifter can take a new reply.
   logic                      tx_load;
   spi_frame_pkg::frame_word_u tx_word;

   modport port (
      output rx_valid, rx_word, tx_free,
      input  rx_ack, tx_load, tx_word
   );

   modport decoder (
      input  rx_valid, rx_word, tx_free,
      output rx_ack, tx_load, tx_word
   );

endinterface

/* src/reg_map_pkg.sv */
// Register map and status encoding

package reg_map_pkg;

   localparam int REG_WIDTH = 16; // stored bits per register.

   typedef logic [REG_WIDTH-1:0] reg_word_t;

   typedef enum logic [3:0] {
      CMD_NOP   = 4'h0,
      CMD_WRITE = 4'h1,
      CMD_READ  = 4'h2
   } cmd_e;

   // reply status byte.
   localparam int STAT_OK_BIT  = 0;
   localparam int STAT_ERR_BIT = 1;
   localparam int STAT_CMD_LSB = 4; // command echo.
   localparam int STAT_CMD_MSB = 7;

endpackage

/* src/spi_frame_pkg.sv */
// SPI frame layout
// command and reply views of one shift word

package spi_frame_pkg;

   localparam int FRAME_BITS = 32; // sck cycles per frame.

   typedef struct packed {
      logic [3:0] cmd;  // command code.
      logic [3:0] addr; // register address.
   } opcode_s;

   typedef struct packed {
      logic [7:0] byte2;
      logic [7:0] byte1;
      logic [7:0] byte0;
      opcode_s    opcode; // first byte on the wire.
   } cmd_frame_s;

   typedef struct packed {
      logic [23:0] data;
      logic [7:0]  status; // first byte on the wire.
   } rsp_frame_s;

   // received words are read as commands, sent words are built as replies.
   typedef union packed {
      cmd_frame_s cmd;
      rsp_frame_s rsp;
   } frame_word_u;

endpackage
